// ==== uart_apb_slave.f ====
hw/uart_apb_pkg.sv
hw/apb_access_decode.sv
hw/uart_config_regs.sv
hw/rx_status_regs.sv
hw/uart_apb_slave.sv
test/tb_clock_gen.sv
test/apb_slave_checker.sv
test/tb_uart_apb_slave.sv

// ==== Bender.yml ====
package:
  name: uart_apb_slave

sources:
  # Package first, then the blocks, then the top level
  - hw/uart_apb_pkg.sv
  - hw/apb_access_decode.sv
  - hw/uart_config_regs.sv
  - hw/rx_status_regs.sv
  - hw/uart_apb_slave.sv

  # Testbench
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/apb_slave_checker.sv
      - test/tb_uart_apb_slave.sv

// ==== test/tb_uart_apb_slave.sv ====
/* Testbench top: stimulus table, APB driver tasks,
   DUT, clock generator and checker */
`timescale 1ns/100ps

module tb_uart_apb_slave;

  import uart_apb_pkg::*;

  // Non-default reset values so the reset check means something
  localparam bit_period_t BP_RESET      = 14'h0123;
  localparam data_size_t  DS_RESET      = 4'h8;
  localparam int          RESET_TIMEOUT = 20;
  localparam int          DONE_TIMEOUT  = 10;

  // One bus access per row, flags are {data_ready, overrun, framing}
  typedef struct packed {
    data_t    rx;
    logic [2:0] flags;
    logic     wr;
    addr_t    addr;
    data_t    wdata;
    data_t    exp_rdata;
    logic     exp_err;
  } row_t;

  row_t rows[$];

  logic        tb_clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  data_t       pwdata;
  data_t       prdata;
  logic        pslverr;
  data_t       rx_data;
  logic        data_ready;
  logic        overrun_error;
  logic        framing_error;
  logic        data_read;
  bit_period_t bit_period;
  data_size_t  data_size;
  data_t       table_prdata;
  logic        table_pslverr;
  int          check_total;
  int          check_errors;
  int          access_seen;
  int          timeouts;

  tb_clock_gen u_clock_gen (
    .tb_clk (tb_clk),
    .rst_n  (rst_n)
  );

  uart_apb_slave #(
    .BIT_PERIOD_RESET (BP_RESET),
    .DATA_SIZE_RESET  (DS_RESET)
  ) u_uart_apb_slave (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pslverr       (pslverr),
    .rx_data       (rx_data),
    .data_ready    (data_ready),
    .overrun_error (overrun_error),
    .framing_error (framing_error),
    .data_read     (data_read),
    .bit_period    (bit_period),
    .data_size     (data_size)
  );

  apb_slave_checker #(
    .BIT_PERIOD_RESET (BP_RESET),
    .DATA_SIZE_RESET  (DS_RESET)
  ) u_checker (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .rx_data       (rx_data),
    .data_ready    (data_ready),
    .overrun_error (overrun_error),
    .framing_error (framing_error),
    .prdata        (prdata),
    .pslverr       (pslverr),
    .data_read     (data_read),
    .bit_period    (bit_period),
    .data_size     (data_size),
    .table_prdata  (table_prdata),
    .table_pslverr (table_pslverr),
    .check_count   (check_total),
    .error_count   (check_errors),
    .access_count  (access_seen)
  );

  // ********************************************************************
  // Stimulus table
  // ********************************************************************

  task add_row(input data_t rx, input logic [2:0] flags, input logic wr, input addr_t addr,
               input data_t wdata, input data_t exp_rdata, input logic exp_err);
    row_t r;
    r.rx        = rx;
    r.flags     = flags;
    r.wr        = wr;
    r.addr      = addr;
    r.wdata     = wdata;
    r.exp_rdata = exp_rdata;
    r.exp_err   = exp_err;
    rows.push_back(r);
  endtask

  task build_table;
    // Reset values, UART inputs still active
    add_row(8'hA5, 3'b111, 1'b0, REG_BIT_CR0, 8'h00, 8'h23, 1'b0);
    add_row(8'hA5, 3'b111, 1'b0, REG_BIT_CR1, 8'h00, 8'h01, 1'b0);
    add_row(8'hA5, 3'b111, 1'b0, REG_DATA_CR, 8'h00, 8'h08, 1'b0);
    // Bit period 10
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR0, 8'h0A, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR1, 8'h00, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR0, 8'h00, 8'h0A, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR1, 8'h00, 8'h00, 1'b0);
    // Bit period 1000
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR0, 8'hE8, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR1, 8'h03, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR0, 8'h00, 8'hE8, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR1, 8'h00, 8'h03, 1'b0);
    // Top two bits of the high byte go nowhere
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR1, 8'hFF, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR1, 8'h00, 8'h3F, 1'b0);
    add_row(8'h00, 3'b000, 1'b1, REG_BIT_CR1, 8'h03, 8'h00, 1'b0);
    // Data size
    add_row(8'h00, 3'b000, 1'b1, REG_DATA_CR, 8'hFF, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_DATA_CR, 8'h00, 8'h0F, 1'b0);
    // Status flags, each set during the setup cycle
    add_row(8'h00, 3'b010, 1'b0, REG_ERROR_SR, 8'h00, 8'h02, 1'b0);
    add_row(8'h00, 3'b001, 1'b0, REG_ERROR_SR, 8'h00, 8'h01, 1'b0);
    add_row(8'h00, 3'b100, 1'b0, REG_DATA_SR, 8'h00, 8'h01, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_ERROR_SR, 8'h00, 8'h00, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_DATA_SR, 8'h00, 8'h00, 1'b0);
    // Receive buffer
    add_row(8'h09, 3'b100, 1'b0, REG_RX_DATA, 8'h00, 8'h09, 1'b0);
    add_row(8'h0A, 3'b100, 1'b0, REG_RX_DATA, 8'h00, 8'h0A, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_RX_DATA, 8'h00, 8'h0A, 1'b0);
    // Slave errors
    add_row(8'h00, 3'b000, 1'b1, REG_DATA_SR, 8'h55, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b1, REG_ERROR_SR, 8'h55, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b1, REG_RX_DATA, 8'h55, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b1, 3'd5, 8'h55, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b0, 3'd5, 8'h00, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b1, 3'd7, 8'h55, 8'h00, 1'b1);
    add_row(8'h00, 3'b000, 1'b0, 3'd7, 8'h00, 8'h00, 1'b1);
    // Nothing moved after the bad accesses
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR0, 8'h00, 8'hE8, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_BIT_CR1, 8'h00, 8'h03, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_DATA_CR, 8'h00, 8'h0F, 1'b0);
    add_row(8'h00, 3'b000, 1'b0, REG_RX_DATA, 8'h00, 8'h0A, 1'b0);
  endtask

  // ********************************************************************
  // Driver tasks, everything changes on falling edges
  // ********************************************************************

  // Setup cycle then access cycle
  task apply_row(input row_t r);
    @(negedge tb_clk);
    rx_data       = r.rx;
    data_ready    = r.flags[2];
    overrun_error = r.flags[1];
    framing_error = r.flags[0];
    psel          = 1'b1;
    penable       = 1'b0;
    pwrite        = r.wr;
    paddr         = r.addr;
    pwdata        = r.wdata;
    table_prdata  = r.exp_rdata;
    table_pslverr = r.exp_err;
    @(negedge tb_clk);
    penable = 1'b1;
  endtask

  // Reset may still be X at time zero
  task wait_reset_release(output bit ok);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge tb_clk);
      cycles++;
    end
    ok = (rst_n === 1'b1);
  endtask

  // Checker has to see one access phase per row
  task wait_checks_done(input int target, output bit ok);
    int cycles;
    cycles = 0;
    while (access_seen < target && cycles < DONE_TIMEOUT) begin
      @(negedge tb_clk);
      cycles++;
    end
    ok = (access_seen >= target);
  endtask

  initial begin : stimulus
    bit ok;
    timeouts      = 0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    // UART inputs held active through reset
    rx_data       = 8'hA5;
    data_ready    = 1'b1;
    overrun_error = 1'b1;
    framing_error = 1'b1;
    table_prdata  = '0;
    table_pslverr = 1'b0;
    build_table();

    wait_reset_release(ok);
    if (!ok) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end else begin
      foreach (rows[i]) begin
        apply_row(rows[i]);
      end
      @(negedge tb_clk);
      psel    = 1'b0;
      penable = 1'b0;
      wait_checks_done(rows.size(), ok);
      if (!ok) begin
        $display("Timeout: checker saw fewer access phases than table rows");
        timeouts++;
      end
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_total, check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== test/apb_slave_checker.sv ====
/* Reference model of the register map and comparator
   watching the DUT ports */
`timescale 1ns/100ps

module apb_slave_checker #(
  parameter uart_apb_pkg::bit_period_t BIT_PERIOD_RESET = '0,
  parameter uart_apb_pkg::data_size_t  DATA_SIZE_RESET  = '0
) (
  input  logic                      tb_clk,
  input  logic                      rst_n,
  // Bus as driven by the testbench
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  uart_apb_pkg::addr_t       paddr,
  input  uart_apb_pkg::data_t       pwdata,
  // UART inputs
  input  uart_apb_pkg::data_t       rx_data,
  input  logic                      data_ready,
  input  logic                      overrun_error,
  input  logic                      framing_error,
  // DUT outputs
  input  uart_apb_pkg::data_t       prdata,
  input  logic                      pslverr,
  input  logic                      data_read,
  input  uart_apb_pkg::bit_period_t bit_period,
  input  uart_apb_pkg::data_size_t  data_size,
  // Expected values from the stimulus table
  input  uart_apb_pkg::data_t       table_prdata,
  input  logic                      table_pslverr,
  // Counters
  output int                        check_count,
  output int                        error_count,
  output int                        access_count
);

  import uart_apb_pkg::*;

  // Model copy of the registers
  bit_period_t m_bit_period;
  data_size_t  m_data_size;
  logic        m_ready;
  logic        m_overrun;
  logic        m_framing;
  data_t       m_rx_buf;

  // Per-edge decode of the bus
  logic access_now;
  logic read_now;
  logic bad_now;

  initial begin
    check_count  = 0;
    error_count  = 0;
    access_count = 0;
  end

  task check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("Fail %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  // Status side is read only, 5 and 7 are not mapped at all
  function logic bad_access(input logic wr, input addr_t addr);
    bad_access = (addr == 3'd5) || (addr == 3'd7);
    if (wr && (addr == REG_DATA_SR || addr == REG_ERROR_SR || addr == REG_RX_DATA)) begin
      bad_access = 1'b1;
    end
  endfunction

  function data_t expected_read(input addr_t addr);
    case (addr)
      REG_DATA_SR:  expected_read = {7'b0, m_ready};
      REG_ERROR_SR: expected_read = {6'b0, m_overrun, m_framing};
      REG_BIT_CR0:  expected_read = m_bit_period[7:0];
      REG_BIT_CR1:  expected_read = {2'b0, m_bit_period[13:8]};
      REG_DATA_CR:  expected_read = {4'b0, m_data_size};
      REG_RX_DATA:  expected_read = m_rx_buf;
      default:      expected_read = 8'h00;
    endcase
  endfunction

  // ********************************************************************
  // Compare on the rising edge, then advance the model
  // ********************************************************************

  always @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_bit_period = BIT_PERIOD_RESET;
      m_data_size  = DATA_SIZE_RESET;
      m_ready      = 1'b0;
      m_overrun    = 1'b0;
      m_framing    = 1'b0;
      m_rx_buf     = 8'h00;
    end else begin
      access_now = psel && penable;
      read_now   = access_now && !pwrite;
      bad_now    = access_now && bad_access(pwrite, paddr);

      // Config outputs, every cycle so each write shows up one edge later
      check_value("bit_period", 16'(m_bit_period), 16'(bit_period));
      check_value("data_size", 16'(m_data_size), 16'(data_size));
      check_value("pslverr", 16'(bad_now), 16'(pslverr));
      check_value("data_read", 16'(read_now && paddr == REG_RX_DATA), 16'(data_read));
      check_value("prdata", 16'(read_now ? expected_read(paddr) : 8'h00), 16'(prdata));

      // Table values only count in the access phase
      if (access_now) begin
        access_count++;
        check_value("prdata", 16'(table_prdata), 16'(prdata));
        check_value("pslverr", 16'(table_pslverr), 16'(pslverr));
      end

      // Legal writes land on this edge
      if (access_now && pwrite && !bad_now) begin
        case (paddr)
          REG_BIT_CR0: m_bit_period[7:0]  = pwdata;
          REG_BIT_CR1: m_bit_period[13:8] = pwdata[5:0];
          REG_DATA_CR: m_data_size        = pwdata[3:0];
          default:     ;
        endcase
      end

      // Flags one cycle behind the UART
      m_ready   = data_ready;
      m_overrun = overrun_error;
      m_framing = framing_error;
      if (data_ready) begin
        m_rx_buf = rx_data;
      end
    end
  end

endmodule

// ==== test/tb_clock_gen.sv ====
/* Testbench clock and reset generator */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic tb_clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    tb_clk = 1'b0;
    forever #50 tb_clk = ~tb_clk;
  end

  // Reset held for 4 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge tb_clk);
    @(negedge tb_clk);
    rst_n = 1'b1;
  end

endmodule

// ==== hw/uart_apb_slave.sv ====
/* APB register slave for a UART receiver, top level
   joining access decode, config registers and status registers */
`timescale 1ns/100ps

module uart_apb_slave #(
  parameter uart_apb_pkg::bit_period_t BIT_PERIOD_RESET =
    uart_apb_pkg::BIT_PERIOD_RESET_DEFAULT,
  parameter uart_apb_pkg::data_size_t  DATA_SIZE_RESET  =
    uart_apb_pkg::DATA_SIZE_RESET_DEFAULT
) (
  input  logic                      tb_clk,
  input  logic                      rst_n,
  // APB from the master
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  uart_apb_pkg::addr_t       paddr,
  input  uart_apb_pkg::data_t       pwdata,
  // APB to the master
  output uart_apb_pkg::data_t       prdata,
  output logic                      pslverr,
  // From the UART
  input  uart_apb_pkg::data_t       rx_data,
  input  logic                      data_ready,
  input  logic                      overrun_error,
  input  logic                      framing_error,
  // To the UART
  output logic                      data_read,
  output uart_apb_pkg::bit_period_t bit_period,
  output uart_apb_pkg::data_size_t  data_size
);

  import uart_apb_pkg::*;

  // Decoder strobes
  logic  wr_bit_cr0;
  logic  wr_bit_cr1;
  logic  wr_data_cr;
  logic  rd_rx_data;

  // Readback paths
  data_t cfg_rdata;
  data_t status_rdata;

  // ********************************************************************
  // Block instances
  // ********************************************************************

  // Bus side, combinational
  apb_access_decode u_access_decode (
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .cfg_rdata    (cfg_rdata),
    .status_rdata (status_rdata),
    .wr_bit_cr0   (wr_bit_cr0),
    .wr_bit_cr1   (wr_bit_cr1),
    .wr_data_cr   (wr_data_cr),
    .rd_rx_data   (rd_rx_data),
    .prdata       (prdata),
    .pslverr      (pslverr)
  );

  // Writable config
  uart_config_regs #(
    .BIT_PERIOD_RESET (BIT_PERIOD_RESET),
    .DATA_SIZE_RESET  (DATA_SIZE_RESET)
  ) u_config_regs (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .wr_bit_cr0 (wr_bit_cr0),
    .wr_bit_cr1 (wr_bit_cr1),
    .wr_data_cr (wr_data_cr),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .cfg_rdata  (cfg_rdata),
    .bit_period (bit_period),
    .data_size  (data_size)
  );

  // Read-only status and receive buffer
  rx_status_regs u_rx_status (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .rd_rx_data    (rd_rx_data),
    .paddr         (paddr),
    .rx_data       (rx_data),
    .data_ready    (data_ready),
    .overrun_error (overrun_error),
    .framing_error (framing_error),
    .status_rdata  (status_rdata),
    .data_read     (data_read)
  );

endmodule

// ==== hw/rx_status_regs.sv ====
/* Captured UART status flags, receive data buffer
   and the data_read pulse */
`timescale 1ns/100ps

module rx_status_regs (
  input  logic                tb_clk,
  input  logic                rst_n,
  // From the decoder
  input  logic                rd_rx_data,
  input  uart_apb_pkg::addr_t paddr,
  // From the UART
  input  uart_apb_pkg::data_t rx_data,
  input  logic                data_ready,
  input  logic                overrun_error,
  input  logic                framing_error,
  // Readback to the decoder
  output uart_apb_pkg::data_t status_rdata,
  // To the UART
  output logic                data_read
);

  import uart_apb_pkg::*;

  reg_addr_e reg_sel;

  // Captured flags, one cycle behind the UART
  logic data_ready_q;
  logic overrun_q;
  logic framing_q;

  // Receive buffer
  data_t rx_buf;

  // Assembled status bytes
  data_t data_sr;
  data_t error_sr;

  assign reg_sel = reg_addr_e'(paddr);

  // ********************************************************************
  // Flag capture and receive buffer
  // ********************************************************************

  // Flags follow the UART every edge
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_ready_q <= 1'b0;
      overrun_q    <= 1'b0;
      framing_q    <= 1'b0;
    end else begin
      data_ready_q <= data_ready;
      overrun_q    <= overrun_error;
      framing_q    <= framing_error;
    end
  end

  // Buffer holds the last byte offered with data_ready
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_buf <= '0;
    end else if (data_ready) begin
      rx_buf <= rx_data;
    end
  end

  // ********************************************************************
  // Status bytes and readback
  // ********************************************************************

  always_comb begin
    data_sr                   = '0;
    data_sr[0]                = data_ready_q;
    error_sr                  = '0;
    error_sr[ERR_OVERRUN_BIT] = overrun_q;
    error_sr[ERR_FRAMING_BIT] = framing_q;
  end

  // Zero for config and unmapped addresses
  always_comb begin
    case (reg_sel)
      REG_DATA_SR:  status_rdata = data_sr;
      REG_ERROR_SR: status_rdata = error_sr;
      REG_RX_DATA:  status_rdata = rx_buf;
      default:      status_rdata = '0;
    endcase
  end

  // Tells the UART its byte was taken, same cycle as the access phase
  assign data_read = rd_rx_data;

endmodule

// ==== hw/uart_config_regs.sv ====
/* Bit period and data size configuration registers
   with their readback */
`timescale 1ns/100ps

module uart_config_regs #(
  parameter uart_apb_pkg::bit_period_t BIT_PERIOD_RESET =
    uart_apb_pkg::BIT_PERIOD_RESET_DEFAULT,
  parameter uart_apb_pkg::data_size_t  DATA_SIZE_RESET  =
    uart_apb_pkg::DATA_SIZE_RESET_DEFAULT
) (
  input  logic                      tb_clk,
  input  logic                      rst_n,
  // Write strobes from the decoder
  input  logic                      wr_bit_cr0,
  input  logic                      wr_bit_cr1,
  input  logic                      wr_data_cr,
  input  uart_apb_pkg::addr_t       paddr,
  input  uart_apb_pkg::data_t       pwdata,
  // Readback to the decoder
  output uart_apb_pkg::data_t       cfg_rdata,
  // Config to the UART
  output uart_apb_pkg::bit_period_t bit_period,
  output uart_apb_pkg::data_size_t  data_size
);

  import uart_apb_pkg::*;

  // Bits of the bit period that live in the high register
  localparam int unsigned BP_HI_W = BIT_PERIOD_W - DATA_W;

  reg_addr_e reg_sel;

  assign reg_sel = reg_addr_e'(paddr);

  // ********************************************************************
  // Bit period, written as low byte and high 6 bits
  // ********************************************************************

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_period <= BIT_PERIOD_RESET;
    end else begin
      if (wr_bit_cr0) begin
        bit_period[DATA_W-1:0] <= pwdata;
      end
      // Upper 2 bits of pwdata dropped
      if (wr_bit_cr1) begin
        bit_period[BIT_PERIOD_W-1:DATA_W] <= pwdata[BP_HI_W-1:0];
      end
    end
  end

  // ********************************************************************
  // Data size
  // ********************************************************************

  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_size <= DATA_SIZE_RESET;
    end else if (wr_data_cr) begin
      data_size <= pwdata[DATA_SIZE_W-1:0];
    end
  end

  // Readback, zero extended, zero for addresses owned elsewhere
  always_comb begin
    case (reg_sel)
      REG_BIT_CR0: cfg_rdata = bit_period[DATA_W-1:0];
      REG_BIT_CR1: cfg_rdata = data_t'(bit_period[BIT_PERIOD_W-1:DATA_W]);
      REG_DATA_CR: cfg_rdata = data_t'(data_size);
      default:     cfg_rdata = '0;
    endcase
  end

endmodule

// ==== hw/apb_access_decode.sv ====
/* APB phase decode, per-register write strobes, slave error
   and read data multiplexer */
`timescale 1ns/100ps

module apb_access_decode (
  // APB from the master
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  uart_apb_pkg::addr_t paddr,
  // Readback from the register blocks
  input  uart_apb_pkg::data_t cfg_rdata,
  input  uart_apb_pkg::data_t status_rdata,
  // Strobes to the register blocks
  output logic                wr_bit_cr0,
  output logic                wr_bit_cr1,
  output logic                wr_data_cr,
  output logic                rd_rx_data,
  // APB back to the master
  output uart_apb_pkg::data_t prdata,
  output logic                pslverr
);

  import uart_apb_pkg::*;

  // Decoded register
  reg_addr_e reg_sel;

  // Phase qualifiers
  logic access_phase;
  logic wr_access;
  logic rd_access;

  // Address classes
  logic rd_cfg_sel;
  logic rd_status_sel;
  logic addr_unmapped;

  // ********************************************************************
  // Phase decode
  // ********************************************************************

  assign reg_sel = reg_addr_e'(paddr);

  // Access phase, always one cycle since there are no wait states
  assign access_phase = psel & penable;
  assign wr_access    = access_phase & pwrite;
  assign rd_access    = access_phase & ~pwrite;

  // ********************************************************************
  // Address classification
  // ********************************************************************

  always_comb begin
    rd_cfg_sel    = 1'b0;
    rd_status_sel = 1'b0;
    addr_unmapped = 1'b0;
    case (reg_sel)
      // Status side, all read only
      REG_DATA_SR, REG_ERROR_SR, REG_RX_DATA: begin
        rd_status_sel = 1'b1;
      end
      // Config side, read and write
      REG_BIT_CR0, REG_BIT_CR1, REG_DATA_CR: begin
        rd_cfg_sel = 1'b1;
      end
      // Addresses 5 and 7
      default: begin
        addr_unmapped = 1'b1;
      end
    endcase
  end

  // ********************************************************************
  // Write strobes and read pulse
  // ********************************************************************

  // Only config addresses get a strobe, so bad writes touch nothing
  assign wr_bit_cr0 = wr_access & (reg_sel == REG_BIT_CR0);
  assign wr_bit_cr1 = wr_access & (reg_sel == REG_BIT_CR1);
  assign wr_data_cr = wr_access & (reg_sel == REG_DATA_CR);

  // Buffer read, drives data_read downstream
  assign rd_rx_data = rd_access & (reg_sel == REG_RX_DATA);

  // ********************************************************************
  // Slave error and read data
  // ********************************************************************

  // Unmapped access of either kind, or a write to the status side
  assign pslverr = access_phase & (addr_unmapped | (pwrite & rd_status_sel));

  // Read mux, zero outside a read access phase
  always_comb begin
    prdata = '0;
    if (rd_access) begin
      if (rd_cfg_sel) begin
        prdata = cfg_rdata;
      end else if (rd_status_sel) begin
        prdata = status_rdata;
      end
    end
  end

endmodule

// ==== hw/uart_apb_pkg.sv ====
/* Shared widths, types, register map and reset defaults
   for the UART APB register slave */

package uart_apb_pkg;

  // ********************************************************************
  // Bus and field widths
  // ********************************************************************

  // APB side
  localparam int unsigned ADDR_W = 3;
  localparam int unsigned DATA_W = 8;

  // UART configuration fields
  localparam int unsigned BIT_PERIOD_W = 14;
  localparam int unsigned DATA_SIZE_W  = 4;

  // ********************************************************************
  // Types
  // ********************************************************************

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [BIT_PERIOD_W-1:0] bit_period_t;
  typedef logic [DATA_SIZE_W-1:0]  data_size_t;

  // Register map, addresses 5 and 7 are unmapped
  typedef enum addr_t {
    REG_DATA_SR  = 3'd0,  // Data status, read only
    REG_ERROR_SR = 3'd1,  // Error status, read only
    REG_BIT_CR0  = 3'd2,  // Bit period low byte
    REG_BIT_CR1  = 3'd3,  // Bit period high 6 bits
    REG_DATA_CR  = 3'd4,  // Data size
    REG_RX_DATA  = 3'd6   // Receive buffer, read only
  } reg_addr_e;

  // ********************************************************************
  // Status bit positions
  // ********************************************************************

  // Error status byte layout
  localparam int unsigned ERR_OVERRUN_BIT = 1;
  localparam int unsigned ERR_FRAMING_BIT = 0;

  // ********************************************************************
  // Reset defaults
  // ********************************************************************

  // Config register values out of reset
  localparam bit_period_t BIT_PERIOD_RESET_DEFAULT = '0;
  localparam data_size_t  DATA_SIZE_RESET_DEFAULT  = '0;

endpackage
